/* files.f */
verilog/thor_pkg.sv
verilog/thor_insn_length.sv
verilog/thor_bundle_split.sv
verilog/thor_slot_predecode.sv
verilog/thor_frontend.sv
sim/thor_frontend_props.sv
sim/thor_frontend_tb.sv

/* sim/thor_frontend_tb.sv */
/* front end testbench
   directed bundles, random streaming and reset, checked against a reference model */
`timescale 1ns/1ps
`default_nettype none

module thor_frontend_tb;
	import thor_pkg::*;

	logic clk = 1'b0;
	logic rst = 1'b1;
	logic bundle_valid_i = 1'b0;
	pc_t bundle_pc_i = '0;
	bundle_t bundle_i = '0;
	logic out_valid_o;
	decoded_slot_t [NSLOTS-1:0] slots_o;
	pc_t next_pc_o;

	decoded_slot_t [NSLOTS-1:0] exp_slots_q [$];
	pc_t exp_pc_q [$];
	logic [1:0] vq = '0;         // bundle valid history of the last two cycles
	decoded_slot_t [NSLOTS-1:0] last_slots;
	pc_t last_next_pc;
	logic [31:0] rng = 32'h04e385c4;
	int sent = 0;
	int cycles = 0;

	thor_frontend uut (.*);

	always #4 clk = ~clk;

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [7:0] byte_at(input bundle_t b, input int i);
		if (i < BUNDLE_BYTES)
			return b[i*8 +: 8];
		return 8'h00;   // past the end of the bundle
	endfunction

	// ========================================================================
	// reference model
	// ========================================================================
	function automatic void ref_model(input pc_t pc, input bundle_t b,
		output decoded_slot_t [NSLOTS-1:0] s, output pc_t npc);
		int off;
		int len;
		logic prev;
		logic is_short;
		logic [7:0] p;
		logic [7:0] op;
		logic [7:0] b2;
		logic [7:0] b3;
		logic [7:0] b4;
		off = 0;
		prev = 1'b1;
		s = '0;
		npc = pc;
		for (int k = 0; k < NSLOTS; k++)
		begin
			p  = byte_at(b, off);
			op = byte_at(b, off + 1);
			b2 = byte_at(b, off + 2);
			b3 = byte_at(b, off + 3);
			b4 = byte_at(b, off + 4);
			is_short = (p[3:0] == 4'h0) && (p[7:4] <= 4'h8);
			if (is_short)
				len = (p[7:4] == 4'h0) ? 1 : int'(p[7:4]);
			else if (op inside {OP_NOP, OP_SEI, OP_CLI})
				len = 2;
			else if (op inside {OP_TST, OP_BR, OP_RTS})
				len = 3;
			else if (op inside {OP_JSR, OP_SYS, OP_CMP, OP_CMPI})
				len = 4;
			else
				len = 5;
			prev = prev && (off + len <= BUNDLE_BYTES);
			if (!prev)
				break;
			s[k].valid = 1'b1;
			s[k].pc    = pc + pc_t'(off);
			s[k].len   = len_t'(len);
			if (!is_short)
			begin
				if (op inside {OP_ADD, OP_ADDI, OP_LW})
					s[k].tgt = {1'b0, b4};
				else if (op inside {OP_CMP, OP_CMPI, OP_TST})
					s[k].tgt = TGT_PRED + tgt_reg_t'(b2[3:0]);
				else if (op inside {OP_JSR, OP_SYS})
					s[k].tgt = TGT_BREG + tgt_reg_t'(b2[3:0]);
				else if (op == OP_MTSPR && b3[7:4] == 4'h2)
					s[k].tgt = TGT_SREG + tgt_reg_t'(b3[3:0]);
				s[k].is_mem    = op inside {OP_LW, OP_SW};
				s[k].is_flow   = op inside {OP_JSR, OP_SYS, OP_BR, OP_RTS};
				s[k].has_const = op inside {OP_ADDI, OP_CMPI, OP_LW, OP_SW,
				                            OP_JSR, OP_SYS, OP_BR};
			end
			off = off + len;
			npc = pc + pc_t'(off);
		end
	endfunction

	// ========================================================================
	// checks
	// ========================================================================
	task automatic report_mismatch(input string name, input logic [255:0] got,
		input logic [255:0] exp);
		$display("ERR %0t %s got %h exp %h", $time, name, got, exp);
		$display("Test FAILED");
		$fatal(1);
	endtask

	task automatic check_slot(input string name, input decoded_slot_t got,
		input decoded_slot_t exp);
		if (got !== exp)
			report_mismatch(name, 256'(got), 256'(exp));
	endtask

	task automatic check_pc(input string name, input pc_t got, input pc_t exp);
		if (got !== exp)
			report_mismatch(name, 256'(got), 256'(exp));
	endtask

	task automatic check_valid(input string name, input logic got, input logic exp);
		if (got !== exp)
			report_mismatch(name, 256'(got), 256'(exp));
	endtask

	// outputs sampled mid-cycle while expectations come from the inputs about to be taken
	always @(negedge clk)
	begin
		decoded_slot_t [NSLOTS-1:0] es;
		pc_t enpc;
		if (uut.u_props.fail_count != 0)
		begin
			$display("a protocol assertion on the front end failed");
			$display("Test FAILED");
			$fatal(1);
		end
		else if (rst)
		begin
			vq = '0;
			exp_slots_q.delete();
			exp_pc_q.delete();
		end
		else
		begin
			check_valid("out_valid_o", out_valid_o, vq[1]);
			if (out_valid_o)
			begin
				es = exp_slots_q.pop_front();
				enpc = exp_pc_q.pop_front();
				for (int k = 0; k < NSLOTS; k++)
					check_slot($sformatf("slots_o[%0d]", k), slots_o[k], es[k]);
				check_pc("next_pc_o", next_pc_o, enpc);
				last_slots = slots_o;
				last_next_pc = next_pc_o;
			end
			vq = {vq[0], bundle_valid_i};
			if (bundle_valid_i)
			begin
				ref_model(bundle_pc_i, bundle_i, es, enpc);
				exp_slots_q.push_back(es);
				exp_pc_q.push_back(enpc);
			end
		end
	end

	// ========================================================================
	// stimulus
	// ========================================================================
	task automatic send(input pc_t pc, input bundle_t b);
		@(posedge clk);
		bundle_valid_i <= 1'b1;
		bundle_pc_i <= pc;
		bundle_i <= b;
		sent++;
	endtask

	task automatic drain();
		@(posedge clk);
		bundle_valid_i <= 1'b0;
		do
			@(posedge clk);
		while (vq != 2'b00 || exp_pc_q.size() != 0);
	endtask

	function automatic bundle_t next_random();
		bundle_t b;
		for (int i = 0; i < 4; i++)
		begin
			rng = xorshift(rng);
			b[i*32 +: 32] = rng;
		end
		return b;
	endfunction

	task automatic test_short_forms();
		for (int h = 0; h <= 8; h++)
			send(64'h1000 + 64'(h * 32), {16{8'(h << 4)}});
		drain();
	endtask

	task automatic test_opcode_lengths();
		opcode_t ops [12] = '{OP_NOP, OP_SEI, OP_CLI, OP_TST, OP_BR, OP_RTS, OP_JSR,
		                      OP_SYS, OP_CMP, OP_CMPI, OP_ADD, OP_SW};
		foreach (ops[i])
			send(64'h2000 + 64'(i * 16), {8{ops[i], 8'h01}});
		drain();
	endtask

	task automatic test_overflow();
		send(64'h3000, 128'h80 | (128'h80 << 64));   // two 8-byte short forms fill the bundle
		drain();
		check_valid("slots_o[2].valid", last_slots[2].valid, 1'b0);
		check_slot("slots_o[2]", last_slots[2], '0);
		check_pc("next_pc_o", last_next_pc, 64'h3010);
	endtask

	task automatic test_predecode();
		opcode_t ops [9] = '{OP_ADDI, OP_LW, OP_CMP, OP_JSR, OP_MTSPR, OP_MTSPR, OP_SW,
		                     OP_BR, OP_RTS};
		logic [7:0] b3;
		foreach (ops[i])
		begin
			b3 = (i == 5) ? 8'h37 : 8'h27;   // second MTSPR misses the segment file
			send(64'h4000 + 64'(i * 16), {88'h0, 8'h9E, b3, 8'h3C, ops[i], 8'h01});
		end
		drain();
	endtask

	task automatic test_streaming();
		for (int i = 0; i < 200; i++)
			send({32'h0, xorshift(rng ^ 32'(i))}, next_random());
		drain();
	endtask

	task automatic test_reset_midstream();
		for (int i = 0; i < 6; i++)
			send(64'h5000 + 64'(i * 16), next_random());
		@(posedge clk);
		bundle_valid_i <= 1'b0;
		rst <= 1'b1;
		repeat (2) @(posedge clk);
		rst <= 1'b0;
		repeat (4)
		begin
			@(negedge clk);
			check_valid("out_valid_o", out_valid_o, 1'b0);
		end
	endtask

	// watchdog whose limit grows with each bundle sent
	always @(posedge clk)
	begin
		cycles++;
		if (cycles > 16 * sent + 200)
		begin
			$display("timeout: the front end stopped producing results");
			$display("Test FAILED");
			$fatal(1);
		end
	end

	initial
	begin
		repeat (3) @(posedge clk);
		rst <= 1'b0;
		test_short_forms();
		test_opcode_lengths();
		test_overflow();
		test_predecode();
		test_streaming();
		test_reset_midstream();
		if (uut.u_props.fail_count == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* sim/thor_frontend_props.sv */
/* front end protocol properties
   valid latency, slot ordering and reset behavior, bound onto the top level */
`timescale 1ns/1ps
`default_nettype none

module thor_frontend_props
(
	input wire                                            clk,
	input wire                                            rst,
	input wire                                            bundle_valid_i,
	input wire                                            out_valid_o,
	input wire thor_pkg::decoded_slot_t [thor_pkg::NSLOTS-1:0] slots_o
);
	int fail_count = 0;  // failed assertions so far

	// fixed latency of two unless a reset cut the bundle off
	valid_latency: assert property (@(posedge clk) disable iff (rst)
		(!$past(rst, 1) && !$past(rst, 2)) |-> (out_valid_o == $past(bundle_valid_i, 2)))
	else
	begin
		fail_count++;
		$error("out_valid_o does not follow bundle_valid_i by two cycles");
	end

	slot1_order: assert property (@(posedge clk) disable iff (rst)
		slots_o[1].valid |-> slots_o[0].valid)
	else
	begin
		fail_count++;
		$error("slot 1 valid without slot 0");
	end

	slot2_order: assert property (@(posedge clk) disable iff (rst)
		slots_o[2].valid |-> slots_o[1].valid)
	else
	begin
		fail_count++;
		$error("slot 2 valid without slot 1");
	end

	no_stray_slot: assert property (@(posedge clk) disable iff (rst)
		!out_valid_o |-> !(slots_o[0].valid || slots_o[1].valid || slots_o[2].valid))
	else
	begin
		fail_count++;
		$error("slot valid while out_valid_o is low");
	end

	after_reset: assert property (@(posedge clk) $fell(rst) |-> !out_valid_o)
	else
	begin
		fail_count++;
		$error("out_valid_o high right after reset");
	end

endmodule

bind thor_frontend thor_frontend_props u_props
(
	.clk            (clk),
	.rst            (rst),
	.bundle_valid_i (bundle_valid_i),
	.out_valid_o    (out_valid_o),
	.slots_o        (slots_o)
);

`default_nettype wire

/* verilog/thor_frontend.sv */
/* instruction front end top
   two-stage split and predecode of a fetch bundle, plus next fetch pc */
`timescale 1ns/1ps
`default_nettype none

module thor_frontend
(
	input  wire                                            clk,
	input  wire                                            rst,
	input  wire                                            bundle_valid_i,
	input  wire thor_pkg::pc_t                             bundle_pc_i,
	input  wire thor_pkg::bundle_t                         bundle_i,
	output logic                                           out_valid_o,
	output thor_pkg::decoded_slot_t [thor_pkg::NSLOTS-1:0] slots_o,
	output thor_pkg::pc_t                                  next_pc_o
);
	import thor_pkg::*;

	logic                     stage_valid;
	split_slot_t [NSLOTS-1:0] split_slots;
	pc_t                      stage_next_pc;

	// stage 1
	thor_bundle_split u_split
	(
		.clk            (clk),
		.rst            (rst),
		.bundle_valid_i (bundle_valid_i),
		.bundle_pc_i    (bundle_pc_i),
		.bundle_i       (bundle_i),
		.stage_valid_o  (stage_valid),
		.slots_o        (split_slots),
		.next_pc_o      (stage_next_pc)
	);

	// stage 2, one predecoder per slot
	genvar g;
	generate
		for (g = 0; g < NSLOTS; g++)
		begin : g_pre
			thor_slot_predecode u_pre
			(
				.clk    (clk),
				.rst    (rst),
				.slot_i (split_slots[g]),
				.slot_o (slots_o[g])
			);
		end
	endgenerate

	// bundle valid and next pc ride alongside stage 2
	always_ff @(posedge clk)
	begin
		next_pc_o <= stage_next_pc;
		if (rst)
			out_valid_o <= 1'b0;
		else
			out_valid_o <= stage_valid;
	end

endmodule

`default_nettype wire

/* verilog/thor_slot_predecode.sv */
/* slot predecoder, pipeline stage 2
   target register and class flags for one split instruction */
`timescale 1ns/1ps
`default_nettype none

module thor_slot_predecode
(
	input  wire                     clk,
	input  wire                     rst,
	input  wire thor_pkg::split_slot_t slot_i,
	output thor_pkg::decoded_slot_t slot_o
);
	import thor_pkg::*;

	opcode_t    opc;
	logic [7:0] b2;
	logic [7:0] b3;
	logic [7:0] b4;
	logic       short_f;
	tgt_reg_t   tgt;
	logic       is_mem;
	logic       is_flow;
	logic       has_const;

	assign opc     = slot_i.insn[15:8];
	assign b2      = slot_i.insn[23:16];
	assign b3      = slot_i.insn[31:24];
	assign b4      = slot_i.insn[39:32];
	assign short_f = short_form(slot_i.insn[7:0]);  // no opcode byte in a short form

	// ==========================================================================
	// target and class decode
	// ==========================================================================
	always_comb
	begin
		tgt       = TGT_NONE;
		is_mem    = 1'b0;
		is_flow   = 1'b0;
		has_const = 1'b0;
		if (!short_f)
		begin
			case (opc)
			OP_ADD, OP_ADDI, OP_LW:
				tgt = {1'b0, b4};                          // general reg in byte 4
			OP_CMP, OP_CMPI, OP_TST:
				tgt = TGT_PRED + tgt_reg_t'(b2[3:0]);
			OP_JSR, OP_SYS:
				tgt = TGT_BREG + tgt_reg_t'(b2[3:0]);      // link register
			OP_MTSPR:
				if (b3[7:4] == 4'h2)                       // segment regs only
					tgt = TGT_SREG + tgt_reg_t'(b3[3:0]);
			default:
				tgt = TGT_NONE;
			endcase

			is_mem    = opc inside {OP_LW, OP_SW};
			is_flow   = opc inside {OP_JSR, OP_SYS, OP_BR, OP_RTS};
			has_const = opc inside {OP_ADDI, OP_CMPI, OP_LW, OP_SW,
			                        OP_JSR, OP_SYS, OP_BR};
		end
	end

	// ==========================================================================
	// output register
	// ==========================================================================
	always_ff @(posedge clk)
	begin
		slot_o <= '{valid:     slot_i.valid,
		            pc:        slot_i.pc,
		            len:       slot_i.len,
		            tgt:       tgt,
		            is_mem:    is_mem,
		            is_flow:   is_flow,
		            has_const: has_const};
		if (rst)
			slot_o.valid <= 1'b0;
	end

endmodule

`default_nettype wire

/* verilog/thor_bundle_split.sv */
/* fetch bundle splitter, pipeline stage 1
   chains length decoders across the bundle and registers up to three slots */
`timescale 1ns/1ps
`default_nettype none

module thor_bundle_split
(
	input  wire                                          clk,
	input  wire                                          rst,
	input  wire                                          bundle_valid_i,
	input  wire thor_pkg::pc_t                           bundle_pc_i,
	input  wire thor_pkg::bundle_t                       bundle_i,
	output logic                                         stage_valid_o,
	output thor_pkg::split_slot_t [thor_pkg::NSLOTS-1:0] slots_o,
	output thor_pkg::pc_t                                next_pc_o
);
	import thor_pkg::*;

	offs_t                    offs [NSLOTS+1];  // offs[k] = start of slot k, offs[k+1] = its end
	logic [NSLOTS:0]          vld;              // vld[k+1] is slot k valid
	split_slot_t [NSLOTS-1:0] slots_d;
	offs_t                    used;             // bytes consumed by valid slots

	assign offs[0] = '0;
	assign vld[0]  = bundle_valid_i;

	// ==========================================================================
	// length ripple chain
	// ==========================================================================
	genvar g;
	generate
		for (g = 0; g < NSLOTS; g++)
		begin : g_slot
			bundle_t win;   // bundle shifted so the slot starts at byte 0
			len_t    ilen;
			insn_t   mask;

			assign win = bundle_i >> {offs[g], 3'b000};

			thor_insn_length u_len
			(
				.first_i (win[15:0]),
				.len_o   (ilen)
			);

			assign offs[g+1] = offs[g] + offs_t'(ilen);
			// must fit in the bundle, and nothing after a dropped slot
			assign vld[g+1]  = vld[g] && (offs[g+1] <= offs_t'(BUNDLE_BYTES));
			assign mask      = ~({64{1'b1}} << {ilen, 3'b000});  // keep ilen low bytes

			assign slots_d[g] = vld[g+1] ?
				split_slot_t'{valid: 1'b1,
				              pc:    bundle_pc_i + pc_t'(offs[g]),
				              insn:  win[63:0] & mask,
				              len:   ilen} :
				'0;
		end
	endgenerate

	// validity is monotone, so the last valid end is the total
	always_comb
	begin
		used = '0;
		for (int k = 1; k <= NSLOTS; k++)
			if (vld[k])
				used = offs[k];
	end

	// ==========================================================================
	// stage register
	// ==========================================================================
	always_ff @(posedge clk)
	begin
		slots_o   <= slots_d;
		next_pc_o <= bundle_pc_i + pc_t'(used);
		if (rst)
		begin
			stage_valid_o <= 1'b0;
			for (int k = 0; k < NSLOTS; k++)
				slots_o[k].valid <= 1'b0;
		end
		else
			stage_valid_o <= bundle_valid_i;
	end

endmodule

`default_nettype wire

/* verilog/thor_insn_length.sv */
/* instruction length decoder
   length in bytes from the predicate and opcode bytes of one instruction */
`timescale 1ns/1ps
`default_nettype none

module thor_insn_length
(
	input  wire [15:0]     first_i,  // {opcode, predicate}
	output thor_pkg::len_t len_o
);
	import thor_pkg::*;

	logic [7:0] pred;
	opcode_t    opc;

	assign pred = first_i[7:0];
	assign opc  = first_i[15:8];

	always_comb
	begin
		if (short_form(pred))
			len_o = (pred[7:4] == 4'h0) ? len_t'(1) : len_t'(pred[7:4]);  // 00 still takes a byte
		else
		begin
			case (opc)
			OP_NOP, OP_SEI, OP_CLI:          len_o = len_t'(2);
			OP_TST, OP_BR, OP_RTS:           len_o = len_t'(3);
			OP_JSR, OP_SYS, OP_CMP, OP_CMPI: len_o = len_t'(4);
			default:                         len_o = len_t'(5);
			endcase
		end
	end

endmodule

`default_nettype wire

/* verilog/thor_pkg.sv */
/* thor front end shared definitions
   widths, opcode subset, unified register-space bases and stage handoff structs */
`default_nettype none

package thor_pkg;

	// ==========================================================================
	// widths
	// ==========================================================================
	typedef logic [63:0]  pc_t;       // program counter
	typedef logic [127:0] bundle_t;   // 16-byte fetch bundle
	typedef logic [63:0]  insn_t;     // one instruction, zero padded to 8 bytes
	typedef logic [3:0]   len_t;      // instruction length in bytes
	typedef logic [4:0]   offs_t;     // byte offset / running length sum
	typedef logic [7:0]   opcode_t;
	typedef logic [8:0]   tgt_reg_t;  // unified target register

	localparam int BUNDLE_BYTES = 16;
	localparam int NSLOTS       = 3;  // instructions taken per bundle

	// ==========================================================================
	// opcodes (subset handled by the front end)
	// ==========================================================================
	localparam opcode_t OP_NOP   = 8'h10;
	localparam opcode_t OP_SEI   = 8'h30;
	localparam opcode_t OP_CLI   = 8'h31;
	localparam opcode_t OP_TST   = 8'h38;
	localparam opcode_t OP_CMP   = 8'h39;
	localparam opcode_t OP_CMPI  = 8'h3A;
	localparam opcode_t OP_ADD   = 8'h40;
	localparam opcode_t OP_BR    = 8'h46;
	localparam opcode_t OP_ADDI  = 8'h48;
	localparam opcode_t OP_MTSPR = 8'h4F;
	localparam opcode_t OP_RTS   = 8'h60;
	localparam opcode_t OP_JSR   = 8'h61;
	localparam opcode_t OP_SYS   = 8'h62;
	localparam opcode_t OP_LW    = 8'h86;
	localparam opcode_t OP_SW    = 8'h93;

	// register space layout
	// 000-0FF general registers, 1xx special files by high nibble
	localparam tgt_reg_t TGT_NONE = 9'h000;
	localparam tgt_reg_t TGT_PRED = 9'h100;  // predicate registers
	localparam tgt_reg_t TGT_BREG = 9'h110;  // branch registers
	localparam tgt_reg_t TGT_SREG = 9'h120;  // segment registers

	// ==========================================================================
	// pipeline structs
	// ==========================================================================

	// stage 1 -> stage 2, one per slot
	typedef struct packed {
		logic  valid;
		pc_t   pc;
		insn_t insn;   // bytes beyond len are zero
		len_t  len;
	} split_slot_t;

	// predecoded slot as seen by the outside
	typedef struct packed {
		logic     valid;
		pc_t      pc;
		len_t     len;
		tgt_reg_t tgt;
		logic     is_mem;
		logic     is_flow;
		logic     has_const;
	} decoded_slot_t;

	// predicate byte that encodes its own length in the high nibble
	function automatic logic short_form(input logic [7:0] pred);
		return (pred[3:0] == 4'h0) && (pred[7:4] <= 4'h8);
	endfunction

endpackage

`default_nettype wire
